// ==== design/rd_dispatch_defs.svh ====
// Read dispatch constants
`ifndef RD_DISPATCH_DEFS_SVH
`define RD_DISPATCH_DEFS_SVH

// host bus widths
`define RD_ADDR_W 64
`define RD_LEN_W 32
`define RD_ID_W 16
`define RD_DATA_W 512

// one beat is 64 bytes and one burst is 64 beats
`define RD_BEAT_SHIFT 6
`define RD_MAX_BEATS 64
`define RD_BURST_BYTES 4096

// queue sizes
`define JOB_FIFO_DEPTH 16
`define JOB_FIFO_AFULL 12
`define TAG_FIFO_DEPTH 8
`define TAG_FIFO_AFULL 6

`endif

// ==== design/rd_dispatch_pkg.sv ====
// Read dispatch types
`default_nettype none

`include "rd_dispatch_defs.svh"

package rd_dispatch_pkg;

	// byte length split at the beat and 4 KB block boundaries
	typedef struct packed {
		logic [`RD_LEN_W-2*`RD_BEAT_SHIFT-1:0] blocks;	// whole 4 KB blocks
		logic [`RD_BEAT_SHIFT-1:0] beats;	// beats in the last block
		logic [`RD_BEAT_SHIFT-1:0] frac;	// bytes past the last beat
	} rd_len_fields_t;

	typedef union packed {
		logic [`RD_LEN_W-1:0] bytes;
		rd_len_fields_t f;
	} rd_len_u;

	// one entry of the job queue
	typedef struct packed {
		logic [`RD_ADDR_W-1:0] src_addr;
		logic [`RD_LEN_W-`RD_BEAT_SHIFT-1:0] beats;	// length rounded up to beats
		logic [`RD_ID_W-1:0] job_id;
	} rd_job_t;

endpackage

`default_nettype wire

// ==== design/job_intake.sv ====
// Job intake stage
`timescale 1ns/1ps
`default_nettype none

`include "rd_dispatch_defs.svh"

module job_intake import rd_dispatch_pkg::*; (
	input wire clk,
	input wire rst_n,

	input wire job_valid_i,
	input wire [`RD_ADDR_W-1:0] src_addr_i,
	input wire [`RD_LEN_W-1:0] length_i,
	input wire [`RD_ID_W-1:0] job_id_i,

	output logic push_o,
	output rd_job_t job_o
);

	rd_len_u len_in;
	logic [`RD_LEN_W-`RD_BEAT_SHIFT-1:0] beats_whole;
	logic [`RD_LEN_W-`RD_BEAT_SHIFT-1:0] beats_rnd;
	logic has_frac;

	assign len_in.bytes = length_i;
	assign beats_whole = {len_in.f.blocks, len_in.f.beats};	// length in complete beats
	assign has_frac = |len_in.f.frac;	// a partial beat still costs a full one

	assign beats_rnd = beats_whole + {{(`RD_LEN_W-`RD_BEAT_SHIFT-1){1'b0}}, has_frac};

	// the strobe becomes a one-cycle push toward the job queue
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			push_o <= 1'b0;
		end else begin
			push_o <= job_valid_i;
		end
	end

	always_ff @(posedge clk) begin
		if (job_valid_i) begin
			job_o.src_addr <= src_addr_i;
			job_o.beats <= beats_rnd;
			job_o.job_id <= job_id_i;
		end
	end

endmodule

`default_nettype wire

// ==== design/sync_fifo.sv ====
// Synchronous show-ahead FIFO
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
	parameter int WIDTH = 16,
	parameter int DEPTH = 8,
	parameter int AFULL = 6
) (
	input wire clk,
	input wire rst_n,

	input wire push_i,
	input wire [WIDTH-1:0] din_i,
	input wire pop_i,

	output logic [WIDTH-1:0] dout_o,
	output logic empty_o,
	output logic afull_o
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);
	localparam logic [AW-1:0] LAST_IDX = AW'(DEPTH - 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic full;
	logic wr_en;
	logic rd_en;

	assign full = (count == CW'(DEPTH));
	assign wr_en = push_i && !full;	// a push into a full queue is dropped
	assign rd_en = pop_i && !empty_o;

	assign dout_o = mem[rd_ptr];	// head is always visible
	assign empty_o = (count == '0);
	assign afull_o = (count >= CW'(AFULL));

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= din_i;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= (wr_ptr == LAST_IDX) ? '0 : wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= (rd_ptr == LAST_IDX) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + CW'(wr_en) - CW'(rd_en);
		end
	end

endmodule

`default_nettype wire

// ==== design/rd_burst_gen.sv ====
// Read burst generator
`timescale 1ns/1ps
`default_nettype none

`include "rd_dispatch_defs.svh"

module rd_burst_gen import rd_dispatch_pkg::*; (
	input wire clk,
	input wire rst_n,
	input wire start_i,

	input wire rd_job_t job_i,
	input wire job_empty_i,
	output logic job_pop_o,

	input wire tag_afull_i,
	input wire tags_empty_i,
	input wire intake_busy_i,

	output logic rd_req_o,
	input wire rd_req_ack_i,
	output logic [`RD_ADDR_W-1:0] rd_address_o,
	output logic [7:0] rd_len_o,

	output logic req_taken_o,
	output logic [`RD_ID_W-1:0] req_id_o,

	output logic idle_o
);

	typedef enum logic [2:0] {ST_START, ST_FETCH, ST_ISSUE, ST_REQ, ST_HOLD} state_t;

	state_t state;
	logic [`RD_ADDR_W-1:0] cur_addr;	// address of the next burst
	rd_len_u rem;	// bytes still to request
	logic [`RD_ID_W-1:0] cur_id;
	logic issue_go;
	logic full_burst;
	logic drained;
	logic drain_done;
	logic [1:0] drain_cnt;

	assign job_pop_o = (state == ST_FETCH) && !job_empty_i;
	assign issue_go = (state == ST_ISSUE) && !tag_afull_i;	// no new request near a full tag queue
	assign full_burst = (rem.f.blocks != '0);	// at least 4 KB left
	assign req_taken_o = (state == ST_REQ) && rd_req_ack_i;
	assign req_id_o = cur_id;

	assign drained = job_empty_i && !intake_busy_i && tags_empty_i && (state == ST_FETCH);
	assign drain_done = drained && (drain_cnt == 2'd3);	// fourth drained cycle in a row

	// current job and the fields of the burst being requested
	always_ff @(posedge clk) begin
		if (job_pop_o) begin
			cur_addr <= job_i.src_addr;
			rem.bytes <= {job_i.beats, {`RD_BEAT_SHIFT{1'b0}}};
			cur_id <= job_i.job_id;
		end else if (issue_go) begin
			rd_address_o <= cur_addr;
			cur_addr <= cur_addr + `RD_ADDR_W'(`RD_BURST_BYTES);
			if (full_burst) begin
				rd_len_o <= 8'(`RD_MAX_BEATS - 1);
				rem.bytes <= rem.bytes - `RD_LEN_W'(`RD_BURST_BYTES);
			end else begin
				rd_len_o <= {2'b00, rem.f.beats - 6'd1};	// tail burst
				rem.bytes <= '0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ST_START;
			rd_req_o <= 1'b0;
		end else begin
			case (state)
				ST_START: begin
					if (start_i) begin
						state <= ST_FETCH;
					end
				end
				ST_FETCH: begin
					if (!job_empty_i) begin
						state <= ST_ISSUE;
					end else if (drain_done && !start_i) begin
						state <= ST_START;	// operation finished
					end
				end
				ST_ISSUE: begin
					if (!tag_afull_i) begin
						rd_req_o <= 1'b1;
						state <= ST_REQ;
					end
				end
				ST_REQ: begin
					if (rd_req_ack_i) begin
						rd_req_o <= 1'b0;
						state <= ST_HOLD;
					end
				end
				ST_HOLD: begin
					state <= (rem.bytes != '0) ? ST_ISSUE : ST_FETCH;
				end
				default: begin
					state <= ST_START;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			idle_o <= 1'b1;
			drain_cnt <= '0;
		end else begin
			if (start_i) begin
				idle_o <= 1'b0;
			end else if (drain_done) begin
				idle_o <= 1'b1;
			end
			if (start_i || !drained) begin
				drain_cnt <= '0;
			end else if (drain_cnt != 2'd3) begin
				drain_cnt <= drain_cnt + 2'd1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/rd_data_tagger.sv ====
// Read data tagger
`timescale 1ns/1ps
`default_nettype none

`include "rd_dispatch_defs.svh"

module rd_data_tagger (
	input wire clk,
	input wire rst_n,

	input wire req_taken_i,
	input wire [`RD_ID_W-1:0] req_id_i,

	input wire [`RD_DATA_W-1:0] data_in_i,
	input wire valid_in_i,
	input wire rd_last_i,

	output logic [`RD_DATA_W-1:0] data_o,
	output logic data_valid_o,
	output logic [`RD_ID_W-1:0] data_id_o,

	output logic tag_afull_o,
	output logic tags_empty_o
);

	logic [`RD_ID_W-1:0] head_id;	// id of the oldest unfinished burst
	logic burst_end;

	// the next burst may start right after the last beat, so the id leaves with that beat
	assign burst_end = valid_in_i && rd_last_i;

	sync_fifo #(
		.WIDTH(`RD_ID_W),
		.DEPTH(`TAG_FIFO_DEPTH),
		.AFULL(`TAG_FIFO_AFULL)
	) i_tag_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.push_i(req_taken_i),
		.din_i(req_id_i),
		.pop_i(burst_end),
		.dout_o(head_id),
		.empty_o(tags_empty_o),
		.afull_o(tag_afull_o)
	);

	always_ff @(posedge clk) begin
		if (valid_in_i) begin
			data_o <= data_in_i;
			data_id_o <= head_id;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			data_valid_o <= 1'b0;
		end else begin
			data_valid_o <= valid_in_i;
		end
	end

endmodule

`default_nettype wire

// ==== design/rd_dispatch_top.sv ====
// Read dispatch top level
`timescale 1ns/1ps
`default_nettype none

`include "rd_dispatch_defs.svh"

module rd_dispatch_top import rd_dispatch_pkg::*; (
	input wire clk,
	input wire rst_n,
	input wire start_i,
	output logic idle_o,

	input wire job_valid_i,
	input wire [`RD_ADDR_W-1:0] src_addr_i,
	input wire [`RD_LEN_W-1:0] length_i,
	input wire [`RD_ID_W-1:0] job_id_i,
	output logic job_afull_o,

	output logic rd_req_o,
	input wire rd_req_ack_i,
	output logic [`RD_ADDR_W-1:0] rd_address_o,
	output logic [7:0] rd_len_o,

	input wire [`RD_DATA_W-1:0] data_in_i,
	input wire valid_in_i,
	input wire rd_last_i,

	output logic [`RD_DATA_W-1:0] data_o,
	output logic data_valid_o,
	output logic [`RD_ID_W-1:0] data_id_o
);

	logic intake_push;	// also tells the generator a job is in flight
	rd_job_t intake_job;
	rd_job_t head_job;
	logic job_empty;
	logic job_pop;
	logic tag_afull;
	logic tags_empty;
	logic req_taken;
	logic [`RD_ID_W-1:0] req_id;

	job_intake i_intake (
		.clk(clk),
		.rst_n(rst_n),
		.job_valid_i(job_valid_i),
		.src_addr_i(src_addr_i),
		.length_i(length_i),
		.job_id_i(job_id_i),
		.push_o(intake_push),
		.job_o(intake_job)
	);

	sync_fifo #(
		.WIDTH($bits(rd_job_t)),
		.DEPTH(`JOB_FIFO_DEPTH),
		.AFULL(`JOB_FIFO_AFULL)
	) i_job_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.push_i(intake_push),
		.din_i(intake_job),
		.pop_i(job_pop),
		.dout_o(head_job),
		.empty_o(job_empty),
		.afull_o(job_afull_o)
	);

	rd_burst_gen i_burst_gen (
		.clk(clk),
		.rst_n(rst_n),
		.start_i(start_i),
		.job_i(head_job),
		.job_empty_i(job_empty),
		.job_pop_o(job_pop),
		.tag_afull_i(tag_afull),
		.tags_empty_i(tags_empty),
		.intake_busy_i(intake_push),
		.rd_req_o(rd_req_o),
		.rd_req_ack_i(rd_req_ack_i),
		.rd_address_o(rd_address_o),
		.rd_len_o(rd_len_o),
		.req_taken_o(req_taken),
		.req_id_o(req_id),
		.idle_o(idle_o)
	);

	rd_data_tagger i_tagger (
		.clk(clk),
		.rst_n(rst_n),
		.req_taken_i(req_taken),
		.req_id_i(req_id),
		.data_in_i(data_in_i),
		.valid_in_i(valid_in_i),
		.rd_last_i(rd_last_i),
		.data_o(data_o),
		.data_valid_o(data_valid_o),
		.data_id_o(data_id_o),
		.tag_afull_o(tag_afull),
		.tags_empty_o(tags_empty)
	);

endmodule

`default_nettype wire

// ==== tests/tb_rd_dispatch.sv ====
// Read dispatch testbench
`timescale 1ns/1ps
`default_nettype none

`include "rd_dispatch_defs.svh"

module tb_rd_dispatch;

	localparam int WAIT_LIMIT = 200;	// cycles before a wait counts as a stall

	logic clk;
	logic rst_n;
	logic start_i;
	logic idle_o;
	logic job_valid_i;
	logic [`RD_ADDR_W-1:0] src_addr_i;
	logic [`RD_LEN_W-1:0] length_i;
	logic [`RD_ID_W-1:0] job_id_i;
	logic job_afull_o;
	logic rd_req_o;
	logic rd_req_ack_i;
	logic [`RD_ADDR_W-1:0] rd_address_o;
	logic [7:0] rd_len_o;
	logic [`RD_DATA_W-1:0] data_in_i;
	logic valid_in_i;
	logic rd_last_i;
	logic [`RD_DATA_W-1:0] data_o;
	logic data_valid_o;
	logic [`RD_ID_W-1:0] data_id_o;

	logic [`RD_ADDR_W-1:0] job_src[$];
	logic [`RD_LEN_W-1:0] job_len[$];
	logic [`RD_ID_W-1:0] job_id[$];
	logic [`RD_ADDR_W-1:0] exp_addr[$];
	logic [7:0] exp_len[$];
	logic [`RD_ID_W-1:0] exp_id[$];
	integer seed = 32'h899;

	rd_dispatch_top i_dut (.*);

	always #50 clk = ~clk;

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("TB FAILED");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [511:0] got, input logic [511:0] exp);
		if (got !== exp) begin
			fail_run($sformatf("FAILED %s got %0h expected %0h", name, got, exp));
		end
	endtask

	task automatic load_vectors();
		int fd;
		int n;
		string line;
		logic [7:0] kind;
		logic [63:0] a;
		logic [31:0] b;
		logic [15:0] c;
		fd = $fopen("tests/rd_dispatch_vectors.txt", "r");
		if (fd == 0) fail_run("cannot open the vector file");
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line[0] == "#") continue;	// comments and blank lines
			n = $sscanf(line, "%c %h %h %h", kind, a, b, c);
			if (n != 4) fail_run($sformatf("malformed vector line: %s", line));
			if (kind == "J") begin
				job_src.push_back(a);
				job_len.push_back(b);
				job_id.push_back(c);
			end else if (kind == "B") begin
				exp_addr.push_back(a);
				exp_len.push_back(b[7:0]);
				exp_id.push_back(c);
			end else begin
				fail_run($sformatf("unknown vector line: %s", line));
			end
		end
		$fclose(fd);
		if (job_src.size() == 0 || exp_addr.size() == 0) fail_run("vector file holds no jobs");
	endtask

	// one-cycle job strobe that waits while the job queue is almost full
	task automatic send_job(input int idx);
		int waited;
		waited = 0;
		while (job_afull_o) begin
			if (waited == WAIT_LIMIT) fail_run("job queue stayed almost full");
			@(negedge clk);
			waited++;
		end
		job_valid_i = 1'b1;
		src_addr_i = job_src[idx];
		length_i = job_len[idx];
		job_id_i = job_id[idx];
		@(negedge clk);
		job_valid_i = 1'b0;
	endtask

	// answer one request after a random delay and return its data
	task automatic serve_burst(input int idx);
		int waited;
		int delay;
		logic [`RD_ADDR_W-1:0] addr;
		logic [7:0] len;
		logic [`RD_DATA_W-1:0] beat;
		waited = 0;
		while (!rd_req_o) begin
			if (waited == WAIT_LIMIT) fail_run($sformatf("no read request for burst %0d", idx));
			@(negedge clk);
			waited++;
		end
		addr = rd_address_o;
		len = rd_len_o;
		check("rd_address_o", 512'(addr), 512'(exp_addr[idx]));
		check("rd_len_o", 512'(len), 512'(exp_len[idx]));
		delay = $random(seed) % 6;
		if (delay < 0) delay = -delay;
		repeat (delay) begin
			@(negedge clk);
			check("rd_req_o", 512'(rd_req_o), 512'(1));	// request waits for its ack
			check("rd_address_o", 512'(rd_address_o), 512'(addr));
			check("rd_len_o", 512'(rd_len_o), 512'(len));
		end
		rd_req_ack_i = 1'b1;
		@(negedge clk);
		rd_req_ack_i = 1'b0;
		check("rd_req_o", 512'(rd_req_o), 512'(0));
		for (int k = 0; k <= int'(len); k++) begin
			for (int w = 0; w < `RD_DATA_W / 32; w++) begin
				beat = {beat[`RD_DATA_W-33:0], $random(seed)};
			end
			data_in_i = beat;
			valid_in_i = 1'b1;
			rd_last_i = (k == int'(len));	// final beat of the burst
			@(negedge clk);
			check("data_valid_o", 512'(data_valid_o), 512'(1));
			check("data_o", data_o, beat);
			check("data_id_o", 512'(data_id_o), 512'(exp_id[idx]));
		end
		valid_in_i = 1'b0;
		rd_last_i = 1'b0;
	endtask

	initial begin
		int waited;
		clk = 1'b0;
		rst_n = 1'b0;
		start_i = 1'b0;
		job_valid_i = 1'b0;
		src_addr_i = '0;
		length_i = '0;
		job_id_i = '0;
		rd_req_ack_i = 1'b0;
		data_in_i = '0;
		valid_in_i = 1'b0;
		rd_last_i = 1'b0;
		load_vectors();
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		check("idle_o", 512'(idle_o), 512'(1));
		check("rd_req_o", 512'(rd_req_o), 512'(0));
		check("data_valid_o", 512'(data_valid_o), 512'(0));
		check("job_afull_o", 512'(job_afull_o), 512'(0));

		// jobs wait in the queue until start
		for (int i = 0; i < job_src.size(); i++) begin
			send_job(i);
		end
		repeat (5) begin
			@(negedge clk);
			check("rd_req_o", 512'(rd_req_o), 512'(0));
		end
		check("idle_o", 512'(idle_o), 512'(1));

		start_i = 1'b1;
		@(negedge clk);
		start_i = 1'b0;
		check("idle_o", 512'(idle_o), 512'(0));

		for (int i = 0; i < exp_addr.size(); i++) begin
			serve_burst(i);
		end

		waited = 0;
		while (!idle_o) begin
			if (waited == WAIT_LIMIT) fail_run("idle_o never rose after the jobs drained");
			@(negedge clk);
			waited++;
		end
		repeat (10) begin
			@(negedge clk);
			check("idle_o", 512'(idle_o), 512'(1));
			check("rd_req_o", 512'(rd_req_o), 512'(0));	// no burst beyond the list
		end

		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== rd_dispatch_top.f ====
+incdir+design
design/rd_dispatch_pkg.sv
design/job_intake.sv
design/sync_fifo.sv
design/rd_burst_gen.sv
design/rd_data_tagger.sv
design/rd_dispatch_top.sv
tests/tb_rd_dispatch.sv

// ==== Makefile ====
# Verilator build and run of the read dispatch testbench

SIM := obj_dir/Vtb_rd_dispatch
SRCS := $(shell grep -v '^+' rd_dispatch_top.f) design/rd_dispatch_defs.svh

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): rd_dispatch_top.f $(SRCS)
	verilator --binary --timing --top-module tb_rd_dispatch -f rd_dispatch_top.f

run: $(SIM)
	-$(SIM) > sim.log 2>&1
	@cat sim.log
	@if grep -q "TB FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "TB PASSED" sim.log || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log

// ==== tests/rd_dispatch_vectors.txt ====
# J src_addr length job_id : one job per line, sent in this order
# B address rd_len job_id : expected read bursts in issue order
J 0000000010000000 00000100 0001
J 0000000020000040 00000041 0002
J 00000000300000c0 00000010 0003
J 0000000140000000 00001001 0004
J 0000000050001000 00001000 0005
J ffffffff00000000 00002800 0006
J 0000000070000000 00001fc1 0007
B 0000000010000000 03 0001
B 0000000020000040 01 0002
B 00000000300000c0 00 0003
B 0000000140000000 3f 0004
B 0000000140001000 00 0004
B 0000000050001000 3f 0005
B ffffffff00000000 3f 0006
B ffffffff00001000 3f 0006
B ffffffff00002000 1f 0006
B 0000000070000000 3f 0007
B 0000000070001000 3f 0007
